//--- fsab_mem_pkg.sv
package fsab_mem_pkg;

	localparam int FSAB_DATA_W = 64;
	localparam int FSAB_MASK_W = 8;		// Bit set means byte is skipped
	localparam int FSAB_DID_W = 4;
	localparam int FSAB_ADDR_W = 31;
	localparam int FSAB_LEN_W = 4;
	localparam int FSAB_LEN_MAX = 8;
	localparam int FSAB_CREDITS = 4;

	localparam int APP_DATA_W = 128;	// Two bus beats per memory word
	localparam int APP_MASK_W = 16;

	localparam int WDATA_DEPTH = FSAB_CREDITS * FSAB_LEN_MAX / 2;
	localparam int RDATA_DEPTH = 16;
	localparam int CREDIT_W = $clog2(FSAB_CREDITS + 1);
	localparam int RWORD_CNT_W = $clog2(RDATA_DEPTH + 1);

	typedef enum logic {FSAB_READ = 1'b0, FSAB_WRITE = 1'b1} fsab_mode_e;
	typedef enum logic {APP_WRITE = 1'b0, APP_READ = 1'b1} app_cmd_e;

	typedef struct packed {
		fsab_mode_e mode;
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_ADDR_W-1:0] addr;
		logic [FSAB_LEN_W-1:0] len;		// Beats in the burst, 1 to 8
	} fsab_req_t;

	typedef struct packed {
		logic [APP_DATA_W-1:0] data;	// Later beat in the upper half
		logic [APP_MASK_W-1:0] mask;
	} app_wword_t;

	typedef struct packed {
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_LEN_W-1:0] len;
	} resp_hdr_t;

	// Memory words needed for a burst of len beats
	function automatic logic [FSAB_LEN_W-1:0] app_words(input logic [FSAB_LEN_W-1:0] len);
		logic [FSAB_LEN_W:0] sum;
		sum = {1'b0, len} + 1'b1;
		return sum[FSAB_LEN_W:1];
	endfunction

endpackage

//--- burst_if.sv
`timescale 1ns/1ps

interface burst_if;
	import fsab_mem_pkg::*;

	logic load;
	logic [FSAB_LEN_W-1:0] beats;
	logic step;
	logic last;		// One beat left
	logic busy;		// Burst in progress

	modport ctl (output load, output beats, output step, input last, input busy);
	modport cnt (input load, input beats, input step, output last, output busy);

endinterface

//--- fsab_fifo.sv
`timescale 1ns/1ps

module fsab_fifo #(
	parameter type T = logic,
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst_b,
	input logic push,
	input T din,
	input logic pop,
	output T dout,
	output logic empty,
	output logic full
);
	localparam int AW = $clog2(DEPTH);

	T mem [DEPTH];
	logic [AW:0] wr_ptr;		// Extra bit tells full from empty
	logic [AW:0] rd_ptr;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= din;
	end

	assign dout = mem[rd_ptr[AW-1:0]];		// Show-ahead head entry
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_b) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_b) pop |-> !empty);

endmodule

//--- beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
	input logic clk,
	input logic rst_b,
	burst_if.cnt bus
);
	import fsab_mem_pkg::*;

	logic [FSAB_LEN_W-1:0] count;		// Beats still to go

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			count <= '0;
		end else if (bus.load) begin
			count <= bus.beats;
		end else if (bus.step) begin
			count <= count - 1'b1;
		end
	end

	assign bus.busy = (count != '0);
	assign bus.last = (count == FSAB_LEN_W'(1));

	// The controller only steps an active burst
	a_step_when_busy: assert property (@(posedge clk) disable iff (!rst_b)
		bus.step |-> bus.busy);

endmodule

//--- fsab_wr_packer.sv
`timescale 1ns/1ps

module fsab_wr_packer (
	input logic clk,
	input logic rst_b,
	input logic fsabo_valid,
	input fsab_mem_pkg::fsab_mode_e fsabo_mode,
	input logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabo_did,
	input logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabo_subdid,
	input logic [fsab_mem_pkg::FSAB_ADDR_W-1:0] fsabo_addr,
	input logic [fsab_mem_pkg::FSAB_LEN_W-1:0] fsabo_len,
	input logic [fsab_mem_pkg::FSAB_DATA_W-1:0] fsabo_data,
	input logic [fsab_mem_pkg::FSAB_MASK_W-1:0] fsabo_mask,
	output logic req_push,
	output fsab_mem_pkg::fsab_req_t req_din,
	output logic wd_push,
	output fsab_mem_pkg::app_wword_t wd_din
);
	import fsab_mem_pkg::*;

	logic [FSAB_LEN_W-1:0] beats_left;		// Write beats after the current one
	logic hdr_cycle;
	logic data_beat;
	logic last_beat;
	logic have_low;		// Even beat waiting for its partner
	logic [FSAB_DATA_W-1:0] low_data;
	logic [FSAB_MASK_W-1:0] low_mask;
	fsab_req_t hdr_live;
	fsab_req_t hdr_q;

	assign hdr_cycle = fsabo_valid && (beats_left == '0);
	assign data_beat = (fsabo_valid && (beats_left != '0)) ||
	                   (hdr_cycle && (fsabo_mode == FSAB_WRITE));
	assign last_beat = hdr_cycle ? (fsabo_len == FSAB_LEN_W'(1)) :
	                               (beats_left == FSAB_LEN_W'(1));

	assign hdr_live = '{mode: fsabo_mode, did: fsabo_did, subdid: fsabo_subdid,
	                    addr: fsabo_addr, len: fsabo_len};

	// Header goes in once all of its data is queued
	assign req_push = (hdr_cycle && (fsabo_mode == FSAB_READ)) || (data_beat && last_beat);
	assign req_din = hdr_cycle ? hdr_live : hdr_q;

	assign wd_push = data_beat && (have_low || last_beat);
	assign wd_din.data = have_low ? {fsabo_data, low_data} :
	                                {{FSAB_DATA_W{1'b0}}, fsabo_data};
	assign wd_din.mask = have_low ? {fsabo_mask, low_mask} :
	                                {{FSAB_MASK_W{1'b1}}, fsabo_mask};		// Pad odd tail

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			beats_left <= '0;
			have_low <= 1'b0;
		end else begin
			if (hdr_cycle && (fsabo_mode == FSAB_WRITE))
				beats_left <= fsabo_len - 1'b1;
			else if (fsabo_valid && (beats_left != '0))
				beats_left <= beats_left - 1'b1;
			if (data_beat)
				have_low <= !have_low && !last_beat;
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_cycle)
			hdr_q <= hdr_live;
		if (data_beat && !have_low) begin
			low_data <= fsabo_data;
			low_mask <= fsabo_mask;
		end
	end

endmodule

//--- mem_cmd_fsm.sv
`timescale 1ns/1ps

module mem_cmd_fsm (
	input logic clk,
	input logic rst_b,
	input logic app_ready,
	input logic req_empty,
	input fsab_mem_pkg::fsab_req_t req_dout,
	output logic req_pop,
	input fsab_mem_pkg::app_wword_t wd_dout,
	output logic wd_pop,
	output logic app_cmd_valid,
	output fsab_mem_pkg::app_cmd_e app_cmd,
	output logic [fsab_mem_pkg::FSAB_ADDR_W-1:0] app_addr,
	output logic app_wdata_valid,
	output logic [fsab_mem_pkg::APP_DATA_W-1:0] app_wdata,
	output logic [fsab_mem_pkg::APP_MASK_W-1:0] app_wmask,
	input logic rsp_done,
	output logic fsabo_credit
);
	import fsab_mem_pkg::*;

	typedef enum logic {IDLE, WRITE} state_e;

	state_e state;
	state_e state_nxt;
	logic start;
	logic is_wr;
	logic wr_done;
	logic [FSAB_LEN_W-1:0] words;
	logic [CREDIT_W-1:0] credit_pend;		// Credits owed to the requester

	burst_if wr_burst ();

	beat_counter u_beat_counter (
		.clk(clk),
		.rst_b(rst_b),
		.bus(wr_burst.cnt)
	);

	assign start = (state == IDLE) && app_ready && !req_empty;
	assign is_wr = (req_dout.mode == FSAB_WRITE);
	assign words = app_words(req_dout.len);

	// First word leaves with the command so the counter holds the rest
	always_comb begin
		state_nxt = state;
		wr_burst.load = 1'b0;
		wr_burst.beats = words - 1'b1;
		wr_burst.step = 1'b0;
		wr_done = 1'b0;
		if (state == IDLE) begin
			if (start && is_wr) begin
				if (words == FSAB_LEN_W'(1)) begin
					wr_done = 1'b1;
				end else begin
					wr_burst.load = 1'b1;
					state_nxt = WRITE;
				end
			end
		end else begin
			wr_burst.step = 1'b1;
			if (wr_burst.last) begin
				wr_done = 1'b1;
				state_nxt = IDLE;
			end
		end
	end

	assign req_pop = start;
	assign app_cmd_valid = start;
	assign app_cmd = is_wr ? APP_WRITE : APP_READ;
	assign app_addr = req_dout.addr;		// Start address only
	assign app_wdata_valid = (start && is_wr) || (state == WRITE);
	assign wd_pop = app_wdata_valid;
	assign app_wdata = wd_dout.data;
	assign app_wmask = wd_dout.mask;

	assign fsabo_credit = (credit_pend != '0);		// One pulse per cycle at most

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state <= IDLE;
			credit_pend <= '0;
		end else begin
			state <= state_nxt;
			credit_pend <= credit_pend + CREDIT_W'(wr_done) + CREDIT_W'(rsp_done) -
			               CREDIT_W'(fsabo_credit);
		end
	end

	// Requester never holds more than its credit pool outstanding
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_b)
		credit_pend <= CREDIT_W'(FSAB_CREDITS));

endmodule

//--- fsab_rd_unpacker.sv
`timescale 1ns/1ps

module fsab_rd_unpacker (
	input logic clk,
	input logic rst_b,
	input logic hdr_push,
	input fsab_mem_pkg::resp_hdr_t hdr_din,
	input logic app_rdata_valid,
	input logic [fsab_mem_pkg::APP_DATA_W-1:0] app_rdata,
	output logic fsabi_valid,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabi_did,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabi_subdid,
	output logic [fsab_mem_pkg::FSAB_DATA_W-1:0] fsabi_data,
	output logic rsp_done
);
	import fsab_mem_pkg::*;

	resp_hdr_t hdr_dout;
	logic hdr_empty;
	logic hdr_pop;
	logic [APP_DATA_W-1:0] rd_dout;
	logic rd_pop;
	logic [RWORD_CNT_W-1:0] word_cnt;		// Read words buffered
	logic start;
	logic hi_half;		// Next beat takes the upper half

	burst_if rsp_burst ();

	fsab_fifo #(.T(resp_hdr_t), .DEPTH(FSAB_CREDITS)) u_hdr_fifo (
		.clk(clk),
		.rst_b(rst_b),
		.push(hdr_push),
		.din(hdr_din),
		.pop(hdr_pop),
		.dout(hdr_dout),
		.empty(hdr_empty),
		.full()
	);

	fsab_fifo #(.T(logic [APP_DATA_W-1:0]), .DEPTH(RDATA_DEPTH)) u_rd_fifo (
		.clk(clk),
		.rst_b(rst_b),
		.push(app_rdata_valid),
		.din(app_rdata),
		.pop(rd_pop),
		.dout(rd_dout),
		.empty(),
		.full()
	);

	beat_counter u_beat_counter (
		.clk(clk),
		.rst_b(rst_b),
		.bus(rsp_burst.cnt)
	);

	// Wait for the whole response so the beats go out back to back
	assign start = !rsp_burst.busy && !hdr_empty &&
	               (word_cnt >= RWORD_CNT_W'(app_words(hdr_dout.len)));
	assign hdr_pop = start;
	assign rsp_burst.load = start;
	assign rsp_burst.beats = hdr_dout.len;
	assign rsp_burst.step = rsp_burst.busy;

	assign rd_pop = rsp_burst.busy && (hi_half || rsp_burst.last);
	assign fsabi_valid = rsp_burst.busy;
	assign fsabi_data = hi_half ? rd_dout[APP_DATA_W-1:FSAB_DATA_W] : rd_dout[FSAB_DATA_W-1:0];
	assign rsp_done = rsp_burst.busy && rsp_burst.last;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			word_cnt <= '0;
			hi_half <= 1'b0;
		end else begin
			word_cnt <= word_cnt + RWORD_CNT_W'(app_rdata_valid) - RWORD_CNT_W'(rd_pop);
			if (start)
				hi_half <= 1'b0;
			else if (rsp_burst.busy)
				hi_half <= !hi_half;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			fsabi_did <= hdr_dout.did;		// Held for the whole response
			fsabi_subdid <= hdr_dout.subdid;
		end
	end

endmodule

//--- fsab_mem_bridge.sv
`timescale 1ns/1ps

module fsab_mem_bridge (
	input logic clk,
	input logic rst_b,
	input logic fsabo_valid,
	input fsab_mem_pkg::fsab_mode_e fsabo_mode,
	input logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabo_did,
	input logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabo_subdid,
	input logic [fsab_mem_pkg::FSAB_ADDR_W-1:0] fsabo_addr,
	input logic [fsab_mem_pkg::FSAB_LEN_W-1:0] fsabo_len,
	input logic [fsab_mem_pkg::FSAB_DATA_W-1:0] fsabo_data,
	input logic [fsab_mem_pkg::FSAB_MASK_W-1:0] fsabo_mask,
	output logic fsabo_credit,
	output logic fsabi_valid,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabi_did,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabi_subdid,
	output logic [fsab_mem_pkg::FSAB_DATA_W-1:0] fsabi_data,
	input logic app_ready,
	output logic app_cmd_valid,
	output fsab_mem_pkg::app_cmd_e app_cmd,
	output logic [fsab_mem_pkg::FSAB_ADDR_W-1:0] app_addr,
	output logic app_wdata_valid,
	output logic [fsab_mem_pkg::APP_DATA_W-1:0] app_wdata,
	output logic [fsab_mem_pkg::APP_MASK_W-1:0] app_wmask,
	input logic app_rdata_valid,
	input logic [fsab_mem_pkg::APP_DATA_W-1:0] app_rdata
);
	import fsab_mem_pkg::*;

	logic req_push;
	fsab_req_t req_din;
	logic req_pop;
	fsab_req_t req_dout;
	logic req_empty;
	logic wd_push;
	app_wword_t wd_din;
	logic wd_pop;
	app_wword_t wd_dout;
	logic hdr_push;
	resp_hdr_t rsp_hdr;
	logic rsp_done;

	fsab_wr_packer u_wr_packer (
		.clk(clk),
		.rst_b(rst_b),
		.fsabo_valid(fsabo_valid),
		.fsabo_mode(fsabo_mode),
		.fsabo_did(fsabo_did),
		.fsabo_subdid(fsabo_subdid),
		.fsabo_addr(fsabo_addr),
		.fsabo_len(fsabo_len),
		.fsabo_data(fsabo_data),
		.fsabo_mask(fsabo_mask),
		.req_push(req_push),
		.req_din(req_din),
		.wd_push(wd_push),
		.wd_din(wd_din)
	);

	fsab_fifo #(.T(fsab_req_t), .DEPTH(FSAB_CREDITS)) u_req_fifo (
		.clk(clk),
		.rst_b(rst_b),
		.push(req_push),
		.din(req_din),
		.pop(req_pop),
		.dout(req_dout),
		.empty(req_empty),
		.full()
	);

	fsab_fifo #(.T(app_wword_t), .DEPTH(WDATA_DEPTH)) u_wd_fifo (
		.clk(clk),
		.rst_b(rst_b),
		.push(wd_push),
		.din(wd_din),
		.pop(wd_pop),
		.dout(wd_dout),
		.empty(),
		.full()
	);

	mem_cmd_fsm u_mem_cmd_fsm (
		.clk(clk),
		.rst_b(rst_b),
		.app_ready(app_ready),
		.req_empty(req_empty),
		.req_dout(req_dout),
		.req_pop(req_pop),
		.wd_dout(wd_dout),
		.wd_pop(wd_pop),
		.app_cmd_valid(app_cmd_valid),
		.app_cmd(app_cmd),
		.app_addr(app_addr),
		.app_wdata_valid(app_wdata_valid),
		.app_wdata(app_wdata),
		.app_wmask(app_wmask),
		.rsp_done(rsp_done),
		.fsabo_credit(fsabo_credit)
	);

	// Read requester IDs follow the command into the response path
	assign hdr_push = app_cmd_valid && (app_cmd == APP_READ);
	assign rsp_hdr = '{did: req_dout.did, subdid: req_dout.subdid, len: req_dout.len};

	fsab_rd_unpacker u_rd_unpacker (
		.clk(clk),
		.rst_b(rst_b),
		.hdr_push(hdr_push),
		.hdr_din(rsp_hdr),
		.app_rdata_valid(app_rdata_valid),
		.app_rdata(app_rdata),
		.fsabi_valid(fsabi_valid),
		.fsabi_did(fsabi_did),
		.fsabi_subdid(fsabi_subdid),
		.fsabi_data(fsabi_data),
		.rsp_done(rsp_done)
	);

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_b
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;		// 10 ns period
	end

	initial begin
		rst_b = 1'b0;
		repeat (8) @(posedge clk);
		rst_b <= 1'b1;
	end

endmodule

//--- tb_app_mem_model.sv
`timescale 1ns/1ps

module tb_app_mem_model (
	input logic clk,
	input logic rst_b,
	output logic app_ready,
	input logic app_cmd_valid,
	input fsab_mem_pkg::app_cmd_e app_cmd,
	input logic [fsab_mem_pkg::FSAB_ADDR_W-1:0] app_addr,
	input logic app_wdata_valid,
	input logic [fsab_mem_pkg::APP_DATA_W-1:0] app_wdata,
	input logic [fsab_mem_pkg::APP_MASK_W-1:0] app_wmask,
	output logic app_rdata_valid,
	output logic [fsab_mem_pkg::APP_DATA_W-1:0] app_rdata
);
	import fsab_mem_pkg::*;

	logic [APP_DATA_W-1:0] mem [int];		// Indexed by byte address / 16
	logic [APP_DATA_W-1:0] rq_data [$];
	longint rq_due [$];
	int rd_len_q [$];		// Burst lengths of reads, in command order
	longint cycle = 0;
	longint last_due = 0;
	int ready_left = 0;
	int wptr = 0;
	logic [31:0] lcg_state = 32'd23;

	function automatic logic [63:0] beat_fill(input int b);
		return {32'(b) ^ 32'h5a5a_c3c3, 32'(b) * 32'h9e37_79b9};
	endfunction

	function automatic logic [APP_DATA_W-1:0] read_word(input int w);
		if (mem.exists(w))
			return mem[w];
		return {beat_fill(2 * w + 1), beat_fill(2 * w)};
	endfunction

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task add_read_len(input int len);
		rd_len_q.push_back(len);
	endtask

	always @(posedge clk or negedge rst_b) begin : mem_proc
		logic [31:0] r;
		logic [APP_DATA_W-1:0] word;
		longint due;
		int n;
		int base;
		if (!rst_b) begin
			app_ready <= 1'b0;
			app_rdata_valid <= 1'b0;
			app_rdata <= '0;
		end else begin
			cycle++;
			if (ready_left == 0) begin		// Toggle ready with short low stretches
				r = next_rand();
				app_ready <= !app_ready;
				ready_left = app_ready ? int'(r % 6) : 2 + int'(r % 14);
			end else begin
				ready_left--;
			end
			if (app_cmd_valid && app_cmd == APP_WRITE)
				wptr = int'(app_addr >> 4);
			if (app_cmd_valid && app_cmd == APP_READ) begin
				n = (rd_len_q.size() != 0) ? (rd_len_q.pop_front() + 1) / 2 : 1;
				base = int'(app_addr >> 4);
				r = next_rand();
				due = cycle + 2 + longint'(r % 4);		// Latency 2 to 5
				if (due <= last_due)
					due = last_due + 1;		// Keep reads in order
				for (int j = 0; j < n; j++) begin
					rq_data.push_back(read_word(base + j));
					rq_due.push_back(due + j);
				end
				last_due = due + n - 1;
			end
			if (app_wdata_valid) begin
				word = read_word(wptr);
				for (int i = 0; i < APP_MASK_W; i++) begin
					if (!app_wmask[i])
						word[8*i +: 8] = app_wdata[8*i +: 8];
				end
				mem[wptr] = word;
				wptr++;
			end
			if (rq_due.size() != 0 && rq_due[0] <= cycle) begin
				app_rdata_valid <= 1'b1;
				app_rdata <= rq_data.pop_front();
				void'(rq_due.pop_front());
			end else begin
				app_rdata_valid <= 1'b0;
			end
		end
	end

endmodule

//--- tb_fsab_mem.sv
`timescale 1ns/1ps

module tb_fsab_mem;
	import fsab_mem_pkg::*;

	logic clk;
	logic rst_b;
	logic fsabo_valid;
	fsab_mode_e fsabo_mode;
	logic [FSAB_DID_W-1:0] fsabo_did;
	logic [FSAB_DID_W-1:0] fsabo_subdid;
	logic [FSAB_ADDR_W-1:0] fsabo_addr;
	logic [FSAB_LEN_W-1:0] fsabo_len;
	logic [FSAB_DATA_W-1:0] fsabo_data;
	logic [FSAB_MASK_W-1:0] fsabo_mask;
	logic fsabo_credit;
	logic fsabi_valid;
	logic [FSAB_DID_W-1:0] fsabi_did;
	logic [FSAB_DID_W-1:0] fsabi_subdid;
	logic [FSAB_DATA_W-1:0] fsabi_data;
	logic app_ready;
	logic app_cmd_valid;
	app_cmd_e app_cmd;
	logic [FSAB_ADDR_W-1:0] app_addr;
	logic app_wdata_valid;
	logic [APP_DATA_W-1:0] app_wdata;
	logic [APP_MASK_W-1:0] app_wmask;
	logic app_rdata_valid;
	logic [APP_DATA_W-1:0] app_rdata;

	logic [31:0] lcg_state = 32'd23;
	int sent = 0;		// Stimulus side count
	int issued = 0;		// Same count, seen by the monitor
	int credits_rx = 0;
	int wr_left = 0;
	int rsp_left = 0;
	app_cmd_e cmd_q [$];
	logic [FSAB_ADDR_W-1:0] addr_q [$];
	int words_q [$];
	app_wword_t wword_q [$];
	logic [FSAB_DATA_W-1:0] beat_data_q [$];
	logic [2*FSAB_DID_W-1:0] beat_id_q [$];
	int beat_left_q [$];
	logic [FSAB_DATA_W-1:0] shadow [int];		// Bus beat view of memory

	tb_clk_gen u_clk_gen (.clk(clk), .rst_b(rst_b));

	fsab_mem_bridge u_fsab_mem_bridge (.*);

	tb_app_mem_model u_app_mem (.*);

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [63:0] beat_fill(input int b);
		return {32'(b) ^ 32'h5a5a_c3c3, 32'(b) * 32'h9e37_79b9};
	endfunction

	function automatic logic [63:0] shadow_beat(input int b);
		return shadow.exists(b) ? shadow[b] : beat_fill(b);
	endfunction

	task report_value(input string name, input string exp, input string act);
		$display("[FAIL] %s expected %s actual %s", name, exp, act);
		$display("*** FAILED ***");
		$fatal(1, "value mismatch");
	endtask

	task report_error(input string what);
		$display("Error: %s", what);
		$display("*** FAILED ***");
		$fatal(1, "check failed");
	endtask

	task idle_bus();
		@(posedge clk);
		fsabo_valid <= 1'b0;
	endtask

	task send_req(input fsab_mode_e mode, input logic [FSAB_DID_W-1:0] did,
	              input logic [FSAB_DID_W-1:0] subdid, input logic [FSAB_ADDR_W-1:0] addr,
	              input logic [FSAB_LEN_W-1:0] len);
		int waited;
		int nbeats;
		int base;
		logic [31:0] r;
		logic [63:0] d [8];
		logic [7:0] m [8];
		logic [63:0] merged;
		app_wword_t w;
		waited = 0;
		while (sent - credits_rx >= FSAB_CREDITS) begin
			@(posedge clk);
			fsabo_valid <= 1'b0;
			waited++;
			if (waited > 2000)
				report_error("no credit came back within 2000 cycles");
		end
		nbeats = (mode == FSAB_WRITE) ? int'(len) : 1;
		base = int'(addr >> 4) * 2;
		cmd_q.push_back(mode == FSAB_WRITE ? APP_WRITE : APP_READ);
		addr_q.push_back(addr);
		words_q.push_back((int'(len) + 1) / 2);
		if (mode == FSAB_WRITE) begin
			for (int k = 0; k < 8; k++) begin
				r = next_rand();
				d[k] = {next_rand(), r};
				m[k] = (r[1:0] == 2'b00) ? r[15:8] : 8'h00;		// Some bytes skipped
			end
			for (int j = 0; 2 * j < nbeats; j++) begin
				w.data = {(2 * j + 1 < nbeats) ? d[2*j+1] : 64'h0, d[2*j]};
				w.mask = {(2 * j + 1 < nbeats) ? m[2*j+1] : 8'hff, m[2*j]};
				wword_q.push_back(w);
			end
			for (int k = 0; k < nbeats; k++) begin
				merged = shadow_beat(base + k);
				for (int i = 0; i < 8; i++) begin
					if (!m[k][i])
						merged[8*i +: 8] = d[k][8*i +: 8];
				end
				shadow[base + k] = merged;
			end
		end else begin
			u_app_mem.add_read_len(int'(len));
			for (int k = 0; k < int'(len); k++) begin
				beat_data_q.push_back(shadow_beat(base + k));
				beat_id_q.push_back({did, subdid});
				beat_left_q.push_back(int'(len) - 1 - k);
			end
		end
		sent++;
		for (int k = 0; k < nbeats; k++) begin
			@(posedge clk);
			fsabo_valid <= 1'b1;
			fsabo_mode <= mode;
			fsabo_did <= did;
			fsabo_subdid <= subdid;
			fsabo_addr <= addr;
			fsabo_len <= len;
			fsabo_data <= (mode == FSAB_WRITE) ? d[k] : 64'h0;
			fsabo_mask <= (mode == FSAB_WRITE) ? m[k] : 8'h00;
			if (k == 0)
				issued <= issued + 1;
		end
	endtask

	// Monitor samples at the edge, before the new inputs settle
	always @(posedge clk) begin : monitor
		logic expect_wd;
		int words;
		app_wword_t w;
		words = 0;
		if (issued == 0) begin
			assert (!app_cmd_valid && !app_wdata_valid && !fsabi_valid && !fsabo_credit)
			else report_error("output active before the first request");
		end
		if (rst_b) begin
			if (app_cmd_valid) begin
				if (cmd_q.size() == 0)
					report_error("memory command without a request");
				assert (app_cmd == cmd_q[0])
				else report_value("cmd_kind", $sformatf("%0d", cmd_q[0]), $sformatf("%0d", app_cmd));
				assert (app_addr == addr_q[0])
				else report_value("cmd_addr", $sformatf("%h", addr_q[0]), $sformatf("%h", app_addr));
				void'(cmd_q.pop_front());
				void'(addr_q.pop_front());
				words = words_q.pop_front();
			end
			expect_wd = (app_cmd_valid && app_cmd == APP_WRITE) || (wr_left != 0);
			assert (app_wdata_valid == expect_wd)
			else report_value("wdata_valid", $sformatf("%b", expect_wd),
			                  $sformatf("%b", app_wdata_valid));
			if (app_wdata_valid) begin
				w = wword_q.pop_front();
				assert ({app_wdata, app_wmask} == w)
				else report_value("write_word", $sformatf("%h", w),
				                  $sformatf("%h", {app_wdata, app_wmask}));
			end
			if (app_cmd_valid && app_cmd == APP_WRITE)
				wr_left = words - 1;
			else if (wr_left != 0)
				wr_left--;
			if (rsp_left != 0) begin
				assert (fsabi_valid) else report_error("gap inside a read response");
			end
			if (fsabi_valid) begin
				if (beat_data_q.size() == 0)
					report_error("read beat without a read request");
				assert (fsabi_data == beat_data_q[0])
				else report_value("read_beat", $sformatf("%h", beat_data_q[0]),
				                  $sformatf("%h", fsabi_data));
				assert ({fsabi_did, fsabi_subdid} == beat_id_q[0])
				else report_value("read_ids", $sformatf("%h", beat_id_q[0]),
				                  $sformatf("%h", {fsabi_did, fsabi_subdid}));
				void'(beat_data_q.pop_front());
				void'(beat_id_q.pop_front());
				rsp_left = beat_left_q.pop_front();
			end
			if (fsabo_credit) begin
				assert (credits_rx < issued) else report_error("credit with no request outstanding");
				credits_rx <= credits_rx + 1;
			end
		end
	end

	a_no_cmd_unready: assert property (@(posedge clk) disable iff (!rst_b)
		app_cmd_valid |-> app_ready)
	else report_error("command issued while memory not ready");

	initial begin : stimulus
		int waited;
		fsab_mode_e mode;
		logic [31:0] r;
		fsabo_valid = 1'b0;
		fsabo_mode = FSAB_READ;
		fsabo_did = '0;
		fsabo_subdid = '0;
		fsabo_addr = '0;
		fsabo_len = '0;
		fsabo_data = '0;
		fsabo_mask = '0;
		waited = 0;
		while (!rst_b) begin
			@(posedge clk);
			waited++;
			if (waited > 100)
				report_error("reset never released");
		end
		repeat (5) @(posedge clk);		// Quiet outputs after reset
		send_req(FSAB_WRITE, 4'h1, 4'h2, 31'h100, 4'd5);
		send_req(FSAB_WRITE, 4'h1, 4'h2, 31'h100, 4'd3);
		send_req(FSAB_READ, 4'h3, 4'h4, 31'h100, 4'd8);
		send_req(FSAB_READ, 4'h5, 4'h6, 31'h200, 4'd1);
		for (int i = 0; i < 200; i++) begin
			r = next_rand();
			mode = r[4] ? FSAB_WRITE : FSAB_READ;
			send_req(mode, r[11:8], r[15:12], FSAB_ADDR_W'((next_rand() % 64) * 16),
			         FSAB_LEN_W'(1 + next_rand() % 8));
			if (r[21:20] == 2'b00)
				idle_bus();
		end
		idle_bus();
		waited = 0;
		while (cmd_q.size() != 0 || wword_q.size() != 0 || beat_data_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > 5000)
				report_error("traffic did not drain within 5000 cycles");
		end
		waited = 0;
		while (credits_rx != sent) begin		// Last credits trail the data
			@(posedge clk);
			waited++;
			assert (waited <= 50)
			else report_value("credit_total", $sformatf("%0d", sent), $sformatf("%0d", credits_rx));
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- filelist.f
fsab_mem_pkg.sv
burst_if.sv
fsab_fifo.sv
beat_counter.sv
fsab_wr_packer.sv
mem_cmd_fsm.sv
fsab_rd_unpacker.sv
fsab_mem_bridge.sv
tb_clk_gen.sv
tb_app_mem_model.sv
tb_fsab_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_fsab_mem -f filelist.f -o tb_fsab_mem
./obj_dir/tb_fsab_mem
